// ==== unpack_pkg.sv ====
`default_nettype none

package unpack_pkg;

    // ram address and data word widths
    localparam int ADDR_W = 11;
    localparam int WORD_W = 32;
    // z, x and reconciliation outputs
    localparam int NUM_CH = 3;

    // opcode in the top nibble of the header word
    typedef enum logic [3:0] {
        PKT_Z_BASIS    = 4'd1,
        PKT_X_BASIS    = 4'd2,
        PKT_ASK_PARITY = 4'd3,
        PKT_VERIF_HASH = 4'd4
    } packet_type_e;

    // length code, 257 uses the short length field
    typedef enum logic [3:0] {
        LEN_257  = 4'd0,
        LEN_514  = 4'd1,
        LEN_771  = 4'd2,
        LEN_1028 = 4'd3
    } len_code_e;

    // header word at ram address 0, msb first
    typedef struct packed {
        packet_type_e ptype;
        len_code_e    len_code;
        logic [8:0]   short_len;
        logic [14:0]  reserved;
    } packet_header_t;

    typedef enum logic [2:0] {
        IDLE          = 3'd0,
        READ_HEADER   = 3'd1,
        SET_PARAMETER = 3'd2,
        STREAM        = 3'd3,
        UNPACK_DONE   = 3'd4,
        WAIT_RELEASE  = 3'd5
    } unpack_state_e;

    // output channel index, none means discard
    typedef enum logic [1:0] {
        CH_Z    = 2'd0,
        CH_X    = 2'd1,
        CH_ER   = 2'd2,
        CH_NONE = 2'd3
    } channel_e;

    // z and er entries carry data in the low half only
    typedef struct packed {
        logic        valid;
        logic [63:0] data;
    } chan_entry_t;

endpackage

`default_nettype wire

// ==== unpack_fsm.sv ====
`default_nettype none

module unpack_fsm
    import unpack_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire           msg_valid,
    input  wire           net_busy,
    input  wire           stream_done,
    output logic          unpack_busy,
    output logic          hdr_load,
    output logic          stream_en,
    output logic          clear,
    output unpack_state_e state
);

    unpack_state_e state_nxt;
    // cycles spent in READ_HEADER
    logic [1:0]    rd_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            rd_cnt <= '0;
        end else begin
            state <= state_nxt;
            // counts address 0 plus the two read stages
            if (state == READ_HEADER) begin
                rd_cnt <= rd_cnt + 2'd1;
            end else begin
                rd_cnt <= '0;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // network side must have released the ram
                if (msg_valid && !net_busy) begin
                    state_nxt = READ_HEADER;
                end
            end
            READ_HEADER: begin
                if (rd_cnt == 2'd2) begin
                    state_nxt = SET_PARAMETER;
                end
            end
            SET_PARAMETER: state_nxt = STREAM;
            STREAM: begin
                if (stream_done) begin
                    state_nxt = UNPACK_DONE;
                end
            end
            UNPACK_DONE: state_nxt = WAIT_RELEASE;
            WAIT_RELEASE: begin
                // hold busy until the message is withdrawn
                if (!msg_valid) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    assign unpack_busy = (state != IDLE);
    // registered header word is stable on the third cycle
    assign hdr_load    = (state == READ_HEADER) && (rd_cnt == 2'd2);
    assign stream_en   = (state == STREAM);
    assign clear       = (state == UNPACK_DONE);

endmodule

`default_nettype wire

// ==== header_decoder.sv ====
`default_nettype none

module header_decoder
    import unpack_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 hdr_load,
    input  wire                 clear,
    input  wire packet_header_t hdr_word,
    output logic [ADDR_W-1:0]   depth,
    output channel_e            chan,
    output logic                hdr_first
);

    packet_header_t hdr_q;

    // header held for the whole message
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            hdr_q <= '0;
        end else if (hdr_load) begin
            hdr_q <= hdr_word;
        end
    end

    // length code to payload word count
    always_comb begin
        case (hdr_q.len_code)
            LEN_257:  depth = ADDR_W'(hdr_q.short_len);
            LEN_514:  depth = ADDR_W'(512);
            LEN_771:  depth = ADDR_W'(768);
            LEN_1028: depth = ADDR_W'(1024);
            // unknown codes take the largest packet
            default:  depth = ADDR_W'(1024);
        endcase
    end

    always_comb begin
        case (hdr_q.ptype)
            PKT_Z_BASIS:    chan = CH_Z;
            PKT_X_BASIS:    chan = CH_X;
            PKT_ASK_PARITY: chan = CH_ER;
            PKT_VERIF_HASH: chan = CH_ER;
            default:        chan = CH_NONE;
        endcase
    end

    // reconciliation packets forward their header word
    assign hdr_first = (hdr_q.ptype == PKT_ASK_PARITY) || (hdr_q.ptype == PKT_VERIF_HASH);

endmodule

`default_nettype wire

// ==== payload_reader.sv ====
`default_nettype none

module payload_reader
    import unpack_pkg::*;
#(
    parameter int CREDITS = 4
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                stream_en,
    input  wire                clear,
    input  wire                hdr_first,
    input  wire [ADDR_W-1:0]   depth,
    input  wire [WORD_W-1:0]   ram_rdata,
    input  wire channel_e      chan,
    input  wire [NUM_CH-1:0]   can_take,
    output logic [ADDR_W-1:0]  ram_addr,
    output logic               word_valid,
    output logic               hdr_sent,
    output logic               stream_done,
    output logic [WORD_W-1:0]  word,
    output logic [NUM_CH-1:0]  reserve
);

    logic [ADDR_W-1:0] iss_cnt;
    logic [ADDR_W-1:0] ret_cnt;
    logic [ADDR_W-1:0] total;
    logic [ADDR_W-1:0] addr_nxt;
    logic              need_credit;
    logic              issue;
    // address, ram data and registered data stages
    logic [2:0]        vld_q;
    logic [2:0]        hdr_q;
    logic [WORD_W-1:0] word_q;

    // header word counts as one extra read
    assign total    = depth + ADDR_W'(hdr_first);
    assign addr_nxt = hdr_first ? iss_cnt : iss_cnt + ADDR_W'(1);

    // x needs one entry per pair so odd words ride on the even credit
    assign need_credit = (chan != CH_NONE) && !((chan == CH_X) && iss_cnt[0]);
    assign issue       = stream_en && (iss_cnt < total)
                         && (!need_credit || can_take[chan]);

    always_comb begin
        reserve = '0;
        if (issue && need_credit) begin
            reserve[chan] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            iss_cnt  <= '0;
            ret_cnt  <= '0;
            ram_addr <= '0;
            vld_q    <= '0;
            hdr_q    <= '0;
        end else begin
            vld_q <= {vld_q[1:0], issue};
            hdr_q <= {hdr_q[1:0], issue && hdr_first && (iss_cnt == '0)};
            // address held while stalled
            if (issue) begin
                iss_cnt  <= iss_cnt + ADDR_W'(1);
                ram_addr <= addr_nxt;
            end
            if (vld_q[2]) begin
                ret_cnt <= ret_cnt + ADDR_W'(1);
            end
        end
    end

    // second read stage also serves the header fetch
    always_ff @(posedge clk) begin
        word_q <= ram_rdata;
    end

    assign word        = word_q;
    assign word_valid  = vld_q[2];
    assign hdr_sent    = hdr_q[2];
    assign stream_done = stream_en && (ret_cnt == total);

endmodule

`default_nettype wire

// ==== payload_router.sv ====
`default_nettype none

module payload_router
    import unpack_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               clear,
    input  wire               word_valid,
    input  wire               hdr_sent,
    input  wire [WORD_W-1:0]  word,
    input  wire channel_e     chan,
    output chan_entry_t       entry [NUM_CH]
);

    channel_e          target;
    logic              x_word;
    // high while the even word of a pair is held
    logic              x_phase;
    logic [WORD_W-1:0] x_hold;

    // header pass-through always lands on er
    assign target = hdr_sent ? CH_ER : chan;
    assign x_word = word_valid && (target == CH_X);

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            x_phase <= 1'b0;
        end else if (x_word) begin
            x_phase <= ~x_phase;
        end
    end

    always_ff @(posedge clk) begin
        if (x_word && !x_phase) begin
            x_hold <= word;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            entry[i] = '0;
        end
        entry[CH_Z].valid  = word_valid && (target == CH_Z);
        entry[CH_Z].data   = {32'h0, word};
        entry[CH_ER].valid = word_valid && (target == CH_ER);
        entry[CH_ER].data  = {32'h0, word};
        // earlier word in the upper half
        entry[CH_X].valid  = x_word && x_phase;
        entry[CH_X].data   = {x_hold, word};
    end

endmodule

`default_nettype wire

// ==== credit_port.sv ====
`default_nettype none

module credit_port
    import unpack_pkg::*;
#(
    parameter int CREDITS = 4
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              reserve,
    input  wire              credit_return,
    input  wire chan_entry_t entry_in,
    output chan_entry_t      entry_out,
    output logic             can_take
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] count;
    logic             out_valid;
    logic [63:0]      out_data;

    // taken at issue, given back by the downstream sink
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= CNT_W'(CREDITS);
        end else begin
            case ({reserve, credit_return})
                2'b10:   count <= count - CNT_W'(1);
                2'b01:   count <= count + CNT_W'(1);
                // both or neither leaves the count
                default: count <= count;
            endcase
        end
    end

    assign can_take = (count != '0);

    // output stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= entry_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        out_data <= entry_in.data;
    end

    assign entry_out = '{valid: out_valid, data: out_data};

endmodule

`default_nettype wire

// ==== packet_unpacker.sv ====
`default_nettype none

module packet_unpacker
    import unpack_pkg::*;
#(
    parameter int CREDITS = 4
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               msg_valid,
    input  wire               net_busy,
    input  wire [WORD_W-1:0]  ram_rdata,
    input  wire [NUM_CH-1:0]  credit_return,
    output logic              unpack_busy,
    output logic [ADDR_W-1:0] ram_addr,
    output chan_entry_t       ch_out [NUM_CH]
);

    unpack_state_e     state;
    logic              hdr_load;
    logic              stream_en;
    logic              clear;
    logic              stream_done;
    logic [ADDR_W-1:0] depth;
    channel_e          chan;
    logic              hdr_first;
    logic              word_valid;
    logic              hdr_sent;
    logic [WORD_W-1:0] word;
    packet_header_t    hdr_word;
    logic [NUM_CH-1:0] reserve;
    logic [NUM_CH-1:0] can_take;
    chan_entry_t       route_entry [NUM_CH];

    // header is the registered read word
    assign hdr_word = packet_header_t'(word);

    unpack_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .msg_valid   (msg_valid),
        .net_busy    (net_busy),
        .stream_done (stream_done),
        .unpack_busy (unpack_busy),
        .hdr_load    (hdr_load),
        .stream_en   (stream_en),
        .clear       (clear),
        .state       (state)
    );

    header_decoder u_hdr (
        .clk       (clk),
        .rst_n     (rst_n),
        .hdr_load  (hdr_load),
        .clear     (clear),
        .hdr_word  (hdr_word),
        .depth     (depth),
        .chan      (chan),
        .hdr_first (hdr_first)
    );

    payload_reader #(
        .CREDITS (CREDITS)
    ) u_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .stream_en   (stream_en),
        .clear       (clear),
        .hdr_first   (hdr_first),
        .depth       (depth),
        .ram_rdata   (ram_rdata),
        .chan        (chan),
        .can_take    (can_take),
        .ram_addr    (ram_addr),
        .word_valid  (word_valid),
        .hdr_sent    (hdr_sent),
        .stream_done (stream_done),
        .word        (word),
        .reserve     (reserve)
    );

    payload_router u_router (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .word_valid (word_valid),
        .hdr_sent   (hdr_sent),
        .word       (word),
        .chan       (chan),
        .entry      (route_entry)
    );

    // one credit port per output channel
    for (genvar i = 0; i < NUM_CH; i++) begin : gen_port
        credit_port #(
            .CREDITS (CREDITS)
        ) u_port (
            .clk           (clk),
            .rst_n         (rst_n),
            .reserve       (reserve[i]),
            .credit_return (credit_return[i]),
            .entry_in      (route_entry[i]),
            .entry_out     (ch_out[i]),
            .can_take      (can_take[i])
        );
    end

endmodule

`default_nettype wire

// ==== packet_unpacker_sva.sv ====
`default_nettype none

module packet_unpacker_sva
    import unpack_pkg::*;
#(
    parameter int CREDITS = 4
) (
    input wire                clk,
    input wire                rst_n,
    input wire                msg_valid,
    input wire                net_busy,
    input wire                unpack_busy,
    input wire unpack_state_e state,
    input wire [NUM_CH-1:0]   reserve,
    input wire [NUM_CH-1:0]   can_take,
    input wire [NUM_CH-1:0]   credit_return,
    input wire chan_entry_t   ch_out [NUM_CH]
);

    for (genvar i = 0; i < NUM_CH; i++) begin : gen_chk
        // shadow of the port's credits
        int left;
        // reserved but not yet emitted
        int held;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                left <= CREDITS;
                held <= 0;
            end else begin
                left <= left - int'(reserve[i]) + int'(credit_return[i]);
                held <= held + int'(reserve[i]) - int'(ch_out[i].valid);
            end
        end

        a_no_overdraw: assert property (@(posedge clk) disable iff (!rst_n)
            reserve[i] |-> left != 0)
            else $error("reservation with no credit on channel %0d", i);

        a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
            left <= CREDITS)
            else $error("credits above limit on channel %0d", i);

        a_can_take: assert property (@(posedge clk) disable iff (!rst_n)
            can_take[i] == (left != 0))
            else $error("can_take disagrees with credits on channel %0d", i);

        // every entry was paid for at issue
        a_entry_paid: assert property (@(posedge clk) disable iff (!rst_n)
            ch_out[i].valid |-> held != 0)
            else $error("entry without credit on channel %0d", i);
    end

    // a message is taken only once the network side is idle
    a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(unpack_busy) |-> $past(msg_valid && !net_busy))
        else $error("unpack_busy rose without an accepted message");

    // busy holds while the message is still posted
    a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
        unpack_busy && msg_valid |=> unpack_busy)
        else $error("unpack_busy dropped while msg_valid was high");

    // release one cycle after msg_valid falls
    a_busy_release: assert property (@(posedge clk) disable iff (!rst_n)
        (state == WAIT_RELEASE) && !msg_valid |=> !unpack_busy)
        else $error("unpack_busy did not drop after msg_valid fell");

endmodule

bind packet_unpacker packet_unpacker_sva #(
    .CREDITS (CREDITS)
) u_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .msg_valid     (msg_valid),
    .net_busy      (net_busy),
    .unpack_busy   (unpack_busy),
    .state         (state),
    .reserve       (reserve),
    .can_take      (can_take),
    .credit_return (credit_return),
    .ch_out        (ch_out)
);

`default_nettype wire

// ==== tb_packet_unpacker.sv ====
`default_nettype none

module tb_packet_unpacker
    import unpack_pkg::*;
;

    localparam int CREDITS   = 4;
    localparam int NUM_PKTS  = 8;
    localparam int FAST_BITS = 1;
    localparam int SLOW_BITS = 5;
    localparam int MAX_DELAY = (1 << SLOW_BITS) - 1;
    // every packet at full depth with each word waiting out the slowest credit
    localparam longint LIMIT = longint'(NUM_PKTS * 1040 * (MAX_DELAY + 3) * 40);

    logic              clk = 1'b0;
    logic              rst_n = 1'b0;
    logic              msg_valid = 1'b0;
    logic              net_busy = 1'b0;
    logic [WORD_W-1:0] ram_rdata = '0;
    logic [NUM_CH-1:0] credit_return = '0;
    logic              unpack_busy;
    logic [ADDR_W-1:0] ram_addr;
    chan_entry_t       ch_out [NUM_CH];

    // receive ram with the header at 0 and payload from 1
    logic [WORD_W-1:0] mem [0:1024];
    logic [63:0]       exp_q [NUM_CH][$];
    logic [31:0]       lfsr = 32'h7f4e;
    logic [7:0]        pkt_no = '0;
    int                delay_bits = FAST_BITS;
    // credits owed to the DUT and cycles until the next return
    int                owed [NUM_CH];
    int                wait_cnt [NUM_CH];

    packet_unpacker #(
        .CREDITS (CREDITS)
    ) UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .msg_valid     (msg_valid),
        .net_busy      (net_busy),
        .ram_rdata     (ram_rdata),
        .credit_return (credit_return),
        .unpack_busy   (unpack_busy),
        .ram_addr      (ram_addr),
        .ch_out        (ch_out)
    );

    always #20 clk = ~clk;

    // one cycle read latency
    always @(posedge clk) begin
        ram_rdata <= mem[ram_addr];
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED at %0t: %s = %h, expected %h",
                                      $time, name, got, exp));
        end
    endtask

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int draw_delay(input int nbits);
        int d;
        d = 0;
        for (int b = 0; b < nbits; b++) begin
            lfsr = lfsr_next(lfsr);
            d = (d << 1) | int'(lfsr[0]);
        end
        return d;
    endfunction

    // expected entries per channel and the last payload address
    function automatic logic [ADDR_W-1:0] build_expected(input logic [31:0] hdr);
        logic [ADDR_W-1:0] n;
        logic [ADDR_W-1:0] a;
        case (hdr[27:24])
            LEN_257: n = ADDR_W'(hdr[23:15]);
            LEN_514: n = ADDR_W'(512);
            LEN_771: n = ADDR_W'(768);
            default: n = ADDR_W'(1024);
        endcase
        case (hdr[31:28])
            PKT_Z_BASIS: begin
                for (a = ADDR_W'(1); a <= n; a = a + ADDR_W'(1)) begin
                    exp_q[CH_Z].push_back({32'h0, mem[a]});
                end
            end
            PKT_X_BASIS: begin
                // earlier word of each pair on top
                for (a = ADDR_W'(1); a < n; a = a + ADDR_W'(2)) begin
                    exp_q[CH_X].push_back({mem[a], mem[a + ADDR_W'(1)]});
                end
            end
            PKT_ASK_PARITY, PKT_VERIF_HASH: begin
                exp_q[CH_ER].push_back({32'h0, hdr});
                for (a = ADDR_W'(1); a <= n; a = a + ADDR_W'(1)) begin
                    exp_q[CH_ER].push_back({32'h0, mem[a]});
                end
            end
            // unknown types are dropped
            default: ;
        endcase
        return n;
    endfunction

    // compare every valid output entry against the queue
    always @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (ch_out[i].valid) begin
                    if (exp_q[i].size() == 0) begin
                        stop_with_error($sformatf("unexpected entry on channel %0d at %0t",
                                                  i, $time));
                    end else begin
                        check_value($sformatf("ch_out[%0d].data", i), ch_out[i].data,
                                    exp_q[i].pop_front());
                    end
                end
            end
        end
    end

    // downstream sink returns one credit per entry after a random gap
    always @(posedge clk) begin
        for (int i = 0; i < NUM_CH; i++) begin
            credit_return[i] <= 1'b0;
            if (ch_out[i].valid) begin
                owed[i]++;
            end
            if (wait_cnt[i] > 0) begin
                wait_cnt[i]--;
            end else if (owed[i] > 0) begin
                credit_return[i] <= 1'b1;
                owed[i]--;
                wait_cnt[i] = draw_delay(delay_bits);
            end
        end
    end

    task automatic run_packet(input logic [31:0] hdr, input int bits, input bit hold_busy);
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] last;
        pkt_no = pkt_no + 8'd1;
        // fill depends on packet number and full address
        for (a = ADDR_W'(1); a <= ADDR_W'(1024); a = a + ADDR_W'(1)) begin
            mem[a] = {pkt_no, 13'h1a5b, a};
        end
        mem[0] = hdr;
        last = build_expected(hdr);
        delay_bits <= bits;
        net_busy   <= hold_busy;
        msg_valid  <= 1'b1;
        if (hold_busy) begin
            // must not start while the network side is busy
            repeat (6) begin
                @(posedge clk);
                check_value("unpack_busy", 64'(unpack_busy), 64'd0);
            end
            net_busy <= 1'b0;
        end
        do begin
            @(posedge clk);
        end while (ram_addr != last);
        // done but msg_valid still high
        repeat (8) begin
            @(posedge clk);
            check_value("unpack_busy", 64'(unpack_busy), 64'd1);
        end
        for (int i = 0; i < NUM_CH; i++) begin
            if (exp_q[i].size() != 0) begin
                stop_with_error($sformatf("%0d entries missing on channel %0d after packet %0d",
                                          exp_q[i].size(), i, pkt_no));
            end
        end
        msg_valid <= 1'b0;
        @(posedge clk);
        check_value("unpack_busy", 64'(unpack_busy), 64'd1);
        @(posedge clk);
        check_value("unpack_busy", 64'(unpack_busy), 64'd0);
    endtask

    function automatic logic [31:0] make_header(input logic [3:0] ptype,
                                                input logic [3:0] code,
                                                input logic [8:0] slen);
        return {ptype, code, slen, 15'h0};
    endfunction

    initial begin
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        run_packet(make_header(PKT_Z_BASIS, LEN_257, 9'd20), FAST_BITS, 1'b0);
        run_packet(make_header(PKT_X_BASIS, LEN_514, 9'd0), FAST_BITS, 1'b0);
        run_packet(make_header(PKT_ASK_PARITY, LEN_257, 9'd40), FAST_BITS, 1'b0);
        run_packet(make_header(PKT_VERIF_HASH, LEN_771, 9'd0), FAST_BITS, 1'b0);
        // long credit gaps
        run_packet(make_header(PKT_Z_BASIS, LEN_514, 9'd0), SLOW_BITS, 1'b0);
        run_packet(make_header(PKT_X_BASIS, LEN_257, 9'd64), SLOW_BITS, 1'b0);
        run_packet(make_header(4'd9, LEN_1028, 9'd0), FAST_BITS, 1'b0);
        run_packet(make_header(PKT_Z_BASIS, LEN_257, 9'd9), FAST_BITS, 1'b1);
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        #(LIMIT);
        stop_with_error("watchdog expired before all packets finished");
    end

endmodule

`default_nettype wire

// ==== packet_unpacker.f ====
unpack_pkg.sv
unpack_fsm.sv
header_decoder.sv
payload_reader.sv
payload_router.sv
credit_port.sv
packet_unpacker.sv
packet_unpacker_sva.sv
tb_packet_unpacker.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_packet_unpacker \
    --Mdir obj_dir -o sim_packet_unpacker -f packet_unpacker.f
./obj_dir/sim_packet_unpacker > sim.log 2>&1 || true
cat sim.log
if grep -q "^Finished with no errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
